// File: source/cpu_types_pkg.sv
// core-wide types: data word, cache view of an address
// and the address that receives the hit count
package cpu_types_pkg;

    localparam int WORD_W = 32;

    typedef logic [WORD_W-1:0] word_t;

    // address as the data cache splits it
    typedef struct packed {
        logic [25:0] tag;
        logic [2:0]  idx;
        logic        blkoff;   // word within block
        logic [1:0]  bytoff;
    } dcachef_t;

    // hit count lands here once the flush is done
    localparam word_t HIT_COUNT_ADDR = 32'h0000_3100;

endpackage

// File: source/cache_types_pkg.sv
// data cache geometry, frame and set structs,
// controller states and the flush pointer
package cache_types_pkg;

    localparam int WAYS        = 2;
    localparam int SETS        = 8;
    localparam int BLOCK_WORDS = 2;
    localparam int TAG_BITS    = 26;
    localparam int IDX_BITS    = $clog2(SETS);

    // one way of a set
    typedef struct packed {
        logic                                       valid;
        logic [TAG_BITS-1:0]                        tag;
        cpu_types_pkg::word_t [BLOCK_WORDS-1:0]     data;
        logic                                       dirty;
    } frame_t;

    // lru names the way to evict next
    typedef struct packed {
        frame_t [WAYS-1:0] frame;
        logic              lru;
    } set_t;

    typedef enum logic [3:0] {
        IDLE,
        WB1,
        WB2,
        RD1,
        RD2,
        FLUSH_SCAN,
        FL1,
        FL2,
        COUNT_WR,
        HALTED
    } ctrl_state_t;

    // {set index, way}
    typedef logic [$clog2(SETS*WAYS)-1:0] frame_ptr_t;

endpackage

// File: source/cache_access_if.sv
// decoded request fields and lookup results shared by the cache blocks
interface cache_access_if;

    logic [cache_types_pkg::TAG_BITS-1:0] tag;
    logic [cache_types_pkg::IDX_BITS-1:0] idx;
    logic                                 blkoff;

    logic                 hit;
    logic                 hit_way;
    cpu_types_pkg::word_t hit_word;

    // lru way of the addressed set
    logic                                 victim_way;
    logic                                 victim_valid;
    logic                                 victim_dirty;
    logic [cache_types_pkg::TAG_BITS-1:0] victim_tag;
    cpu_types_pkg::word_t [cache_types_pkg::BLOCK_WORDS-1:0] victim_words;

    logic store_ok;   // SC permission, 1 for plain writes

    modport lookup (
        output tag, idx, blkoff, hit, hit_way, hit_word,
        output victim_way, victim_valid, victim_dirty, victim_tag, victim_words
    );

    modport control (
        input tag, idx, blkoff, hit, hit_way, hit_word,
        input victim_way, victim_valid, victim_dirty, victim_tag, victim_words,
        input store_ok
    );

    modport respond (
        input  hit, hit_word,
        output store_ok
    );

endinterface

// File: source/dcache_lookup.sv
// address split, two-way tag compare, hit word and victim selection
module dcache_lookup (
    input  cpu_types_pkg::word_t   dmemaddr,
    input  cache_types_pkg::set_t  cur_set,
    cache_access_if.lookup         acc
);

    cpu_types_pkg::dcachef_t              addr;
    logic [cache_types_pkg::WAYS-1:0]     match;
    cache_types_pkg::frame_t              victim;

    assign addr = cpu_types_pkg::dcachef_t'(dmemaddr);

    assign acc.tag    = addr.tag;
    assign acc.idx    = addr.idx;
    assign acc.blkoff = addr.blkoff;

    // a way matches only while valid
    always_comb begin
        for (int w = 0; w < cache_types_pkg::WAYS; w++) begin
            match[w] = cur_set.frame[w].valid && (cur_set.frame[w].tag == addr.tag);
        end
    end

    assign acc.hit      = |match;
    assign acc.hit_way  = match[1];   // way 0 when neither matches
    assign acc.hit_word = cur_set.frame[acc.hit_way].data[addr.blkoff];

    // eviction candidate is whatever lru points at
    assign victim = cur_set.frame[cur_set.lru];

    assign acc.victim_way   = cur_set.lru;
    assign acc.victim_valid = victim.valid;
    assign acc.victim_dirty = victim.dirty;
    assign acc.victim_tag   = victim.tag;
    assign acc.victim_words = victim.data;

endmodule

// File: source/dcache_array.sv
// set storage for the data cache, flop based
// combinational read of one set and one flush frame, registered writes
module dcache_array (
    input  logic                                 CLK,
    input  logic                                 nRST,
    input  logic [cache_types_pkg::IDX_BITS-1:0] rd_idx,
    output cache_types_pkg::set_t                rd_set,
    input  cache_types_pkg::frame_ptr_t          flush_ptr,
    output cache_types_pkg::frame_t              flush_frame,
    input  logic                                 wr_en,
    input  logic [cache_types_pkg::IDX_BITS-1:0] wr_idx,
    input  logic                                 wr_way,
    input  cache_types_pkg::frame_t              wr_frame,
    input  logic                                 lru_en,
    input  logic                                 lru_val
);

    cache_types_pkg::set_t [cache_types_pkg::SETS-1:0] sets;

    assign rd_set = sets[rd_idx];

    // pointer is {set, way}
    assign flush_frame = sets[flush_ptr[cache_types_pkg::IDX_BITS:1]].frame[flush_ptr[0]];

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            sets <= '0;
        end else begin
            if (wr_en) begin
                sets[wr_idx].frame[wr_way] <= wr_frame;
            end
            if (lru_en) begin
                sets[wr_idx].lru <= lru_val;   // same set as the frame write
            end
        end
    end

endmodule

// File: source/dcache_control.sv
// miss and flush controller: write-back, refill, flush walk, hit count write
// sole writer of the set array
module dcache_control (
    input  logic                                 CLK,
    input  logic                                 nRST,
    input  logic                                 dmemREN,
    input  logic                                 dmemWEN,
    input  cpu_types_pkg::word_t                 dmemstore,
    input  logic                                 halt,
    cache_access_if.control                      acc,
    input  cache_types_pkg::frame_t              flush_frame,
    output logic                                 wr_en,
    output logic [cache_types_pkg::IDX_BITS-1:0] wr_idx,
    output logic                                 wr_way,
    output cache_types_pkg::frame_t              wr_frame,
    output logic                                 lru_en,
    output logic                                 lru_val,
    output cache_types_pkg::frame_ptr_t          flush_ptr,
    output logic                                 dREN,
    output logic                                 dWEN,
    output cpu_types_pkg::word_t                 daddr,
    output cpu_types_pkg::word_t                 dstore,
    input  cpu_types_pkg::word_t                 dload,
    input  logic                                 dwait,
    output logic                                 in_idle,
    output logic                                 flushed
);

    cache_types_pkg::ctrl_state_t state, nxt_state;
    cache_types_pkg::frame_ptr_t  walk_ptr, nxt_walk_ptr;
    cpu_types_pkg::word_t         hit_count;
    cpu_types_pkg::word_t         refill_w0;
    logic                         refilled;     // last cycle finished a refill
    logic                         count_hit;

    assign in_idle   = (state == cache_types_pkg::IDLE) && !halt;
    assign count_hit = in_idle && dmemREN && acc.hit && !refilled;

    // in IDLE the frame port reads the hit frame, used for write merges
    assign flush_ptr = (state == cache_types_pkg::IDLE) ? {acc.idx, acc.hit_way} : walk_ptr;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state     <= cache_types_pkg::IDLE;
            walk_ptr  <= '0;
            hit_count <= '0;
            refilled  <= 1'b0;
        end else begin
            state    <= nxt_state;
            walk_ptr <= nxt_walk_ptr;
            refilled <= (state == cache_types_pkg::RD2) && !dwait;
            if (count_hit) begin
                hit_count <= hit_count + 1'b1;
            end
        end
    end

    // first refill word waits here for the second
    always_ff @(posedge CLK) begin
        if (state == cache_types_pkg::RD1 && !dwait) begin
            refill_w0 <= dload;
        end
    end

    always_comb begin
        nxt_state    = state;
        nxt_walk_ptr = walk_ptr;
        dREN         = 1'b0;
        dWEN         = 1'b0;
        daddr        = '0;
        dstore       = '0;
        wr_en        = 1'b0;
        wr_idx       = acc.idx;
        wr_way       = acc.hit_way;
        wr_frame     = flush_frame;
        lru_en       = 1'b0;
        lru_val      = ~acc.hit_way;   // other way goes next
        flushed      = 1'b0;
        case (state)
            cache_types_pkg::IDLE: begin
                if (halt) begin
                    nxt_state = cache_types_pkg::FLUSH_SCAN;
                end else if ((dmemREN || dmemWEN) && acc.hit) begin
                    lru_en = 1'b1;
                    if (dmemWEN && acc.store_ok) begin
                        wr_en                     = 1'b1;
                        wr_frame.data[acc.blkoff] = dmemstore;
                        wr_frame.dirty            = 1'b1;
                    end
                end else if (dmemREN || dmemWEN) begin
                    nxt_state = (acc.victim_valid && acc.victim_dirty) ?
                                cache_types_pkg::WB1 : cache_types_pkg::RD1;
                end
            end
            cache_types_pkg::WB1, cache_types_pkg::WB2: begin
                dWEN   = 1'b1;
                daddr  = {acc.victim_tag, acc.idx, state == cache_types_pkg::WB2, 2'b00};
                dstore = acc.victim_words[state == cache_types_pkg::WB2];
                if (!dwait) begin
                    nxt_state = (state == cache_types_pkg::WB1) ?
                                cache_types_pkg::WB2 : cache_types_pkg::RD1;
                end
            end
            cache_types_pkg::RD1: begin
                dREN  = 1'b1;
                daddr = {acc.tag, acc.idx, 1'b0, 2'b00};
                if (!dwait) nxt_state = cache_types_pkg::RD2;
            end
            cache_types_pkg::RD2: begin
                dREN  = 1'b1;
                daddr = {acc.tag, acc.idx, 1'b1, 2'b00};
                if (!dwait) begin   // refill into the victim, clean
                    wr_en     = 1'b1;
                    wr_way    = acc.victim_way;
                    wr_frame  = '{valid: 1'b1, tag: acc.tag, data: {dload, refill_w0},
                                  dirty: 1'b0};
                    nxt_state = cache_types_pkg::IDLE;
                end
            end
            cache_types_pkg::FLUSH_SCAN: begin
                if (flush_frame.valid && flush_frame.dirty) begin
                    nxt_state = cache_types_pkg::FL1;
                end else if (walk_ptr == '1) begin
                    nxt_state = cache_types_pkg::COUNT_WR;
                end else begin
                    nxt_walk_ptr = walk_ptr + 1'b1;
                end
            end
            cache_types_pkg::FL1, cache_types_pkg::FL2: begin
                dWEN   = 1'b1;
                daddr  = {flush_frame.tag, walk_ptr[cache_types_pkg::IDX_BITS:1],
                          state == cache_types_pkg::FL2, 2'b00};
                dstore = flush_frame.data[state == cache_types_pkg::FL2];
                if (!dwait && state == cache_types_pkg::FL1) begin
                    nxt_state = cache_types_pkg::FL2;
                end else if (!dwait) begin
                    // frame now clean, scan sees it again and moves on
                    wr_en          = 1'b1;
                    wr_idx         = walk_ptr[cache_types_pkg::IDX_BITS:1];
                    wr_way         = walk_ptr[0];
                    wr_frame.dirty = 1'b0;
                    nxt_state      = cache_types_pkg::FLUSH_SCAN;
                end
            end
            cache_types_pkg::COUNT_WR: begin
                dWEN   = 1'b1;
                daddr  = cpu_types_pkg::HIT_COUNT_ADDR;
                dstore = hit_count;
                if (!dwait) nxt_state = cache_types_pkg::HALTED;
            end
            cache_types_pkg::HALTED: flushed = 1'b1;   // until reset
            default: nxt_state = cache_types_pkg::IDLE;
        endcase
    end

endmodule

// File: source/dcache_respond.sv
// datapath response: link register, SC decision, dhit and load data
module dcache_respond (
    input  logic                 CLK,
    input  logic                 nRST,
    input  logic                 dmemREN,
    input  logic                 dmemWEN,
    input  logic                 datomic,
    input  cpu_types_pkg::word_t dmemaddr,
    cache_access_if.respond      acc,
    input  logic                 in_idle,
    output logic                 dhit,
    output cpu_types_pkg::word_t dmemload
);

    cpu_types_pkg::word_t link_addr;
    logic                 link_valid;
    logic                 addr_linked;

    assign addr_linked = link_valid && (link_addr == dmemaddr);

    // plain writes always pass
    assign acc.store_ok = !(dmemWEN && datomic) || addr_linked;

    assign dhit = acc.hit && in_idle && (dmemREN || dmemWEN);

    // writes return the SC outcome
    assign dmemload = dmemREN ? acc.hit_word : {31'b0, acc.store_ok};

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            link_valid <= 1'b0;
        end else if (dhit && dmemREN && datomic) begin
            link_valid <= 1'b1;   // LL
        end else if (dhit && dmemWEN && link_addr == dmemaddr) begin
            link_valid <= 1'b0;   // SC done or plain store to the link
        end
    end

    always_ff @(posedge CLK) begin
        if (dhit && dmemREN && datomic) begin
            link_addr <= dmemaddr;
        end
    end

endmodule

// File: source/dcache.sv
// data cache top: datapath and memory ports, lookup, array,
// controller and response blocks
module dcache (
    input  logic                 CLK,
    input  logic                 nRST,
    input  logic                 dmemREN,
    input  logic                 dmemWEN,
    input  logic                 datomic,
    input  cpu_types_pkg::word_t dmemaddr,
    input  cpu_types_pkg::word_t dmemstore,
    input  logic                 halt,
    output logic                 dhit,
    output cpu_types_pkg::word_t dmemload,
    output logic                 flushed,
    output logic                 dREN,
    output logic                 dWEN,
    output cpu_types_pkg::word_t daddr,
    output cpu_types_pkg::word_t dstore,
    input  cpu_types_pkg::word_t dload,
    input  logic                 dwait
);

    cache_types_pkg::set_t                cur_set;
    cache_types_pkg::frame_ptr_t          flush_ptr;
    cache_types_pkg::frame_t              flush_frame;
    cache_types_pkg::frame_t              wr_frame;
    logic [cache_types_pkg::IDX_BITS-1:0] wr_idx;
    logic                                 wr_en;
    logic                                 wr_way;
    logic                                 lru_en;
    logic                                 lru_val;
    logic                                 in_idle;

    cache_access_if acc ();

    dcache_lookup lookup0 (
        .dmemaddr (dmemaddr),
        .cur_set  (cur_set),
        .acc      (acc)
    );

    dcache_array array0 (
        .CLK         (CLK),
        .nRST        (nRST),
        .rd_idx      (acc.idx),
        .rd_set      (cur_set),
        .flush_ptr   (flush_ptr),
        .flush_frame (flush_frame),
        .wr_en       (wr_en),
        .wr_idx      (wr_idx),
        .wr_way      (wr_way),
        .wr_frame    (wr_frame),
        .lru_en      (lru_en),
        .lru_val     (lru_val)
    );

    dcache_control control0 (
        .CLK         (CLK),
        .nRST        (nRST),
        .dmemREN     (dmemREN),
        .dmemWEN     (dmemWEN),
        .dmemstore   (dmemstore),
        .halt        (halt),
        .acc         (acc),
        .flush_frame (flush_frame),
        .wr_en       (wr_en),
        .wr_idx      (wr_idx),
        .wr_way      (wr_way),
        .wr_frame    (wr_frame),
        .lru_en      (lru_en),
        .lru_val     (lru_val),
        .flush_ptr   (flush_ptr),
        .dREN        (dREN),
        .dWEN        (dWEN),
        .daddr       (daddr),
        .dstore      (dstore),
        .dload       (dload),
        .dwait       (dwait),
        .in_idle     (in_idle),
        .flushed     (flushed)
    );

    dcache_respond respond0 (
        .CLK      (CLK),
        .nRST     (nRST),
        .dmemREN  (dmemREN),
        .dmemWEN  (dmemWEN),
        .datomic  (datomic),
        .dmemaddr (dmemaddr),
        .acc      (acc),
        .in_idle  (in_idle),
        .dhit     (dhit),
        .dmemload (dmemload)
    );

endmodule

// File: tests/tb_memory.sv
// memory model for the data cache bus
// word array with a preload pattern, two dwait cycles before each transfer
module tb_memory (
    input  logic                 CLK,
    input  logic                 nRST,
    input  logic                 ren,
    input  logic                 wen,
    input  cpu_types_pkg::word_t addr,
    input  cpu_types_pkg::word_t store,
    output cpu_types_pkg::word_t load,
    output logic                 dwait
);

    cpu_types_pkg::word_t mem [0:4095];   // 16 KB, word indexed
    logic [1:0]           wait_cnt;

    // rotate and xor so that every address bit shows up in the word
    function automatic cpu_types_pkg::word_t fill_word(input cpu_types_pkg::word_t a);
        return {a[15:0], a[31:16]} ^ 32'hc3a5_5a3c;
    endfunction

    initial begin
        for (int i = 0; i < 4096; i++) begin
            mem[i] <= fill_word(cpu_types_pkg::word_t'(i) << 2);
        end
    end

    assign dwait = (ren || wen) && (wait_cnt != 2'd2);
    assign load  = mem[addr[13:2]];

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            wait_cnt <= '0;
        end else begin
            wait_cnt <= ((ren || wen) && dwait) ? wait_cnt + 1'b1 : 2'd0;
        end
    end

    always @(posedge CLK) begin
        if (wen && !dwait) begin
            mem[addr[13:2]] <= store;   // transfer cycle
        end
    end

endmodule

// File: tests/dcache_tb.sv
// data cache testbench: operation table, reference memory,
// 2-way LRU tag model and link register model
module dcache_tb;

    typedef enum logic [2:0] {OP_READ, OP_WRITE, OP_LL, OP_SC, OP_HALT} op_t;

    // exp is the SC result where 1 means stored and 0 refused
    typedef struct packed {
        logic [8*12-1:0]      name;
        op_t                  op;
        cpu_types_pkg::word_t addr;
        cpu_types_pkg::word_t data;
        cpu_types_pkg::word_t exp;
    } step_t;

    localparam int NUM_STEPS     = 21;
    localparam int OP_TIMEOUT    = 64;
    localparam int FLUSH_TIMEOUT = 400;

    // 0x108, 0x148 and 0x188 all land in set 1
    localparam step_t STEPS [NUM_STEPS] = '{
        '{"rd_cold",     OP_READ,  32'h0000_0100, 32'h0,         32'h0},
        '{"rd_cold_nxt", OP_READ,  32'h0000_0104, 32'h0,         32'h0},
        '{"wr_a",        OP_WRITE, 32'h0000_0108, 32'h1111_aaaa, 32'h0},
        '{"rd_a",        OP_READ,  32'h0000_0108, 32'h0,         32'h0},
        '{"wr_b",        OP_WRITE, 32'h0000_0148, 32'h2222_bbbb, 32'h0},
        '{"wr_b_hi",     OP_WRITE, 32'h0000_014c, 32'h2222_bbbc, 32'h0},
        '{"wr_c_evict",  OP_WRITE, 32'h0000_0188, 32'h3333_cccc, 32'h0},
        '{"rd_a_evict",  OP_READ,  32'h0000_0108, 32'h0,         32'h0},
        '{"rd_b_evict",  OP_READ,  32'h0000_014c, 32'h0,         32'h0},
        '{"rd_c",        OP_READ,  32'h0000_0188, 32'h0,         32'h0},
        '{"ll_x",        OP_LL,    32'h0000_0200, 32'h0,         32'h0},
        '{"sc_x",        OP_SC,    32'h0000_0200, 32'h4444_dddd, 32'h1},
        '{"rd_x",        OP_READ,  32'h0000_0200, 32'h0,         32'h0},
        '{"ll_y",        OP_LL,    32'h0000_0204, 32'h0,         32'h0},
        '{"wr_y",        OP_WRITE, 32'h0000_0204, 32'h5555_eeee, 32'h0},
        '{"sc_y_fail",   OP_SC,    32'h0000_0204, 32'h6666_ffff, 32'h0},
        '{"rd_y",        OP_READ,  32'h0000_0204, 32'h0,         32'h0},
        '{"wr_z",        OP_WRITE, 32'h0000_003c, 32'h7777_0101, 32'h0},
        '{"rd_z",        OP_READ,  32'h0000_003c, 32'h0,         32'h0},
        '{"rd_z_lo",     OP_READ,  32'h0000_0038, 32'h0,         32'h0},
        '{"halt",        OP_HALT,  32'h0,         32'h0,         32'h0}
    };

    logic                 CLK = 1'b0;
    logic                 nRST;
    logic                 dmemREN;
    logic                 dmemWEN;
    logic                 datomic;
    logic                 halt;
    cpu_types_pkg::word_t dmemaddr;
    cpu_types_pkg::word_t dmemstore;
    logic                 dhit;
    logic                 flushed;
    cpu_types_pkg::word_t dmemload;
    logic                 dREN;
    logic                 dWEN;
    logic                 dwait;
    cpu_types_pkg::word_t daddr;
    cpu_types_pkg::word_t dstore;
    cpu_types_pkg::word_t dload;

    // reference state
    cpu_types_pkg::word_t ref_mem [0:4095];
    logic                 touched [0:4095];   // written by the datapath
    logic [25:0]          tag_of [8][2];
    logic                 vld [8][2];
    logic                 lru [8];
    logic                 link_valid;
    cpu_types_pkg::word_t link_addr;
    int                   exp_hits;
    int                   mismatches;
    int                   errors;
    logic                 timed_out;

    dcache dut0 (.*);

    tb_memory mem0 (
        .CLK   (CLK),
        .nRST  (nRST),
        .ren   (dREN),
        .wen   (dWEN),
        .addr  (daddr),
        .store (dstore),
        .load  (dload),
        .dwait (dwait)
    );

    initial begin
        forever #2 CLK = ~CLK;
    end

    task automatic check_value(input logic [8*12-1:0] name, input string what,
                               input cpu_types_pkg::word_t exp,
                               input cpu_types_pkg::word_t act);
        assert (act == exp) else begin
            $display("MISMATCH %0s %0s expected %h actual %h", name, what, exp, act);
            mismatches++;
        end
    endtask

    // 2-way LRU model where a miss fills the way lru points at
    task automatic tag_access(input cpu_types_pkg::word_t a, output logic hit);
        logic [2:0] idx;
        logic       way;
        idx = a[5:3];
        hit = 1'b0;
        way = lru[idx];
        for (int w = 0; w < 2; w++) begin
            if (vld[idx][w] && tag_of[idx][w] == a[31:6]) begin
                hit = 1'b1;
                way = w[0];
            end
        end
        vld[idx][way]    = 1'b1;
        tag_of[idx][way] = a[31:6];
        lru[idx]         = ~way;
    endtask

    task automatic run_step(input step_t s);
        logic                 pred_hit;
        logic                 got;
        logic                 sc_ok;
        int                   cycles;
        cpu_types_pkg::word_t load;
        tag_access(s.addr, pred_hit);
        sc_ok = link_valid && link_addr == s.addr;
        @(posedge CLK);
        dmemREN   <= s.op == OP_READ || s.op == OP_LL;
        dmemWEN   <= s.op == OP_WRITE || s.op == OP_SC;
        datomic   <= s.op == OP_LL || s.op == OP_SC;
        dmemaddr  <= s.addr;
        dmemstore <= s.data;
        got    = 1'b0;
        cycles = 0;
        while (!got && cycles < OP_TIMEOUT) begin
            @(negedge CLK);
            cycles++;
            got  = dhit;
            load = dmemload;
        end
        assert (got) else begin
            $display("no dhit for step %0s within %0d cycles", s.name, OP_TIMEOUT);
            errors++;
            timed_out = 1'b1;
        end
        if (got) begin
            check_value(s.name, "hit", pred_hit, cycles == 1);   // a hit answers at once
            if (s.op == OP_READ || s.op == OP_LL) begin
                check_value(s.name, "load", ref_mem[s.addr[13:2]], load);
                exp_hits += pred_hit;
            end
            if (s.op == OP_SC) check_value(s.name, "sc", s.exp, load);
            if (s.op == OP_LL) begin
                link_valid = 1'b1;
                link_addr  = s.addr;
            end
            if (s.op == OP_WRITE || (s.op == OP_SC && sc_ok)) begin
                ref_mem[s.addr[13:2]] = s.data;
                touched[s.addr[13:2]] = 1'b1;
                if (link_addr == s.addr) link_valid = 1'b0;
            end
        end
    endtask

    task automatic run_halt(input logic [8*12-1:0] name);
        logic done;
        int   cycles;
        @(posedge CLK);
        dmemREN <= 1'b0;
        dmemWEN <= 1'b0;
        datomic <= 1'b0;
        halt    <= 1'b1;
        done   = 1'b0;
        cycles = 0;
        while (!done && cycles < FLUSH_TIMEOUT) begin
            @(negedge CLK);
            cycles++;
            done = flushed;
        end
        assert (done) else begin
            $display("flushed did not rise within %0d cycles of halt", FLUSH_TIMEOUT);
            errors++;
            timed_out = 1'b1;
        end
        if (done) begin
            for (int i = 0; i < 4096; i++) begin
                if (touched[i]) begin
                    check_value(name, $sformatf("mem %h", i << 2), ref_mem[i], mem0.mem[i]);
                end
            end
            check_value(name, "hit count", exp_hits,
                        mem0.mem[cpu_types_pkg::HIT_COUNT_ADDR >> 2]);
        end
    endtask

    initial begin
        nRST       = 1'b0;
        dmemREN    = 1'b0;
        dmemWEN    = 1'b0;
        datomic    = 1'b0;
        halt       = 1'b0;
        dmemaddr   = '0;
        dmemstore  = '0;
        mismatches = 0;
        errors     = 0;
        exp_hits   = 0;
        timed_out  = 1'b0;
        link_valid = 1'b0;
        link_addr  = '0;
        vld        = '{default: '{default: 1'b0}};
        lru        = '{default: 1'b0};
        for (int i = 0; i < 4096; i++) begin
            ref_mem[i] = mem0.fill_word(cpu_types_pkg::word_t'(i) << 2);
            touched[i] = 1'b0;
        end
        repeat (16) begin
            @(negedge CLK);
            check_value("reset", "outputs", '0, {dhit, dREN, dWEN, flushed});
        end
        @(posedge CLK);
        nRST <= 1'b1;
        @(negedge CLK);
        check_value("after reset", "outputs", '0, {dhit, dREN, dWEN, flushed});
        for (int i = 0; i < NUM_STEPS && !timed_out; i++) begin
            if (STEPS[i].op == OP_HALT) run_halt(STEPS[i].name);
            else run_step(STEPS[i]);
        end
        $display("mismatches %0d, other errors %0d", mismatches, errors);
        if (mismatches == 0 && errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: dcache.f
source/cpu_types_pkg.sv
source/cache_types_pkg.sv
source/cache_access_if.sv
source/dcache_lookup.sv
source/dcache_array.sv
source/dcache_control.sv
source/dcache_respond.sv
source/dcache.sv
tests/tb_memory.sv
tests/dcache_tb.sv
